/* verilog/bk_pkg.sv */
// shared types for the pipeline back end
// word and register index types, operation enums
// memory word union (whole word or byte lanes)
// data memory size constants
`default_nettype none

package bk_pkg;

    // basic data types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // destination value source
    typedef enum logic [1:0] {
        RD_SRC_ALU = 2'd0,
        RD_SRC_MEM = 2'd1,
        RD_SRC_CSR = 2'd2
    } rd_src_e;

    // memory operation of an instruction
    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_e;

    // access width
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    // one memory word, seen as a word or as four byte lanes
    // lane 0 is the least significant byte (little endian)
    typedef union packed {
        word_t            word;
        logic [3:0][7:0]  lanes;
    } mem_word_u;

    // data memory geometry
    // word address is alu result bits 7:2
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

endpackage

`default_nettype wire

/* verilog/data_mem.sv */
// data memory of the back end
// combinational read port with commit bypass
// byte-enabled commit write port
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                        clk,
    input  logic [bk_pkg::DMEM_AW-1:0]  rd_addr,
    output bk_pkg::word_t               rd_word,
    input  logic                        commit,
    input  logic [bk_pkg::DMEM_AW-1:0]  commit_addr,
    input  logic [3:0]                  commit_be,
    input  bk_pkg::word_t               commit_word
);
    import bk_pkg::*;

    word_t      mem [DMEM_WORDS];
    mem_word_u  commit_u;
    mem_word_u  old_u;
    mem_word_u  wr_u;
    mem_word_u  rd_u;
    mem_word_u  rd_merged_u;
    logic       bypass_hit;

    // replace enabled lanes of old_w with those of new_w
    function automatic mem_word_u merge_lanes(input mem_word_u old_w,
                                              input mem_word_u new_w,
                                              input logic [3:0] be);
        mem_word_u res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res.lanes[i] = new_w.lanes[i];
            end
        end
        return res;
    endfunction

    assign commit_u.word = commit_word;
    assign old_u.word    = mem[commit_addr];
    assign rd_u.word     = mem[rd_addr];

    // read-modify-write of the committed word
    assign wr_u = merge_lanes(old_u, commit_u, commit_be);

    always_ff @(posedge clk) begin
        if (commit) begin
            mem[commit_addr] <= wr_u.word;
        end
    end

    // pending commit to the same word shows up on the read side
    assign bypass_hit  = commit && (commit_addr == rd_addr);
    assign rd_merged_u = merge_lanes(rd_u, commit_u, bypass_hit ? commit_be : 4'b0000);
    assign rd_word     = rd_merged_u.word;

    // every commit writes at least one lane
    a_commit_has_lanes: assert property (@(posedge clk) commit |-> commit_be != 4'b0000);

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
// second memory stage
// input pipeline register, data memory word address
// load lane select with sign/zero extension
// store byte enables and lane replication
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        in_valid,
    input  bk_pkg::reg_idx_t            in_rd_idx,
    input  logic                        in_rd_we,
    input  bk_pkg::rd_src_e             in_rd_src,
    input  bk_pkg::mem_op_e             in_mem_op,
    input  bk_pkg::mem_size_e           in_mem_size,
    input  logic                        in_mem_unsigned,
    input  bk_pkg::word_t               in_alu_result,
    input  bk_pkg::word_t               in_store_data,
    input  bk_pkg::word_t               in_csr_val,
    output logic [bk_pkg::DMEM_AW-1:0]  dmem_addr,
    input  bk_pkg::word_t               dmem_word,
    output logic                        m_valid,
    output bk_pkg::reg_idx_t            m_rd_idx,
    output logic                        m_rd_we,
    output bk_pkg::rd_src_e             m_rd_src,
    output bk_pkg::mem_op_e             m_mem_op,
    output bk_pkg::word_t               m_alu_result,
    output bk_pkg::word_t               m_load_val,
    output bk_pkg::word_t               m_csr_val,
    output logic [bk_pkg::DMEM_AW-1:0]  m_store_addr,
    output logic [3:0]                  m_store_be,
    output bk_pkg::word_t               m_store_word
);
    import bk_pkg::*;

    mem_size_e  ff_mem_size;
    logic       ff_unsigned;
    word_t      ff_store_data;
    mem_word_u  rd_u;
    logic [1:0] byte_off;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;

    // valid bit is the only reset state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (!stall) begin
            m_valid <= in_valid;
        end
    end

    // payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            m_rd_idx      <= in_rd_idx;
            m_rd_we       <= in_rd_we;
            m_rd_src      <= in_rd_src;
            m_mem_op      <= in_mem_op;
            ff_mem_size   <= in_mem_size;
            ff_unsigned   <= in_mem_unsigned;
            m_alu_result  <= in_alu_result;
            ff_store_data <= in_store_data;
            m_csr_val     <= in_csr_val;
        end
    end

    // word address, upper bits ignored
    assign dmem_addr    = m_alu_result[DMEM_AW+1:2];
    assign m_store_addr = dmem_addr;
    assign byte_off     = m_alu_result[1:0];

    // load path, combinational from the memory word
    assign rd_u.word = dmem_word;
    assign ld_byte   = rd_u.lanes[byte_off];
    assign ld_half   = {rd_u.lanes[{byte_off[1], 1'b1}], rd_u.lanes[{byte_off[1], 1'b0}]};

    always_comb begin
        case (ff_mem_size)
            MEM_SIZE_BYTE: m_load_val = {{24{ld_byte[7] & ~ff_unsigned}}, ld_byte};
            MEM_SIZE_HALF: m_load_val = {{16{ld_half[15] & ~ff_unsigned}}, ld_half};
            default:       m_load_val = rd_u.word;
        endcase
    end

    // store data copied into every lane, enables pick the right ones
    always_comb begin
        case (ff_mem_size)
            MEM_SIZE_BYTE: begin
                m_store_be   = 4'b0001 << byte_off;
                m_store_word = {4{ff_store_data[7:0]}};
            end
            MEM_SIZE_HALF: begin
                m_store_be   = 4'b0011 << {byte_off[1], 1'b0};
                m_store_word = {2{ff_store_data[15:0]}};
            end
            default: begin
                m_store_be   = 4'b1111;
                m_store_word = ff_store_data;
            end
        endcase
    end

    // misaligned accesses are not supported
    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && m_mem_op != MEM_OP_NONE && ff_mem_size == MEM_SIZE_HALF |-> !byte_off[0]);
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && m_mem_op != MEM_OP_NONE && ff_mem_size == MEM_SIZE_WORD |-> byte_off == 2'b00);

endmodule

`default_nettype wire

/* verilog/writeback_stage.sv */
// writeback stage
// pipeline register, destination value mux
// register write, store commit, forwarding outputs
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        flush,
    input  logic                        m_valid,
    input  bk_pkg::reg_idx_t            m_rd_idx,
    input  logic                        m_rd_we,
    input  bk_pkg::rd_src_e             m_rd_src,
    input  bk_pkg::mem_op_e             m_mem_op,
    input  bk_pkg::word_t               m_alu_result,
    input  bk_pkg::word_t               m_load_val,
    input  bk_pkg::word_t               m_csr_val,
    input  logic [bk_pkg::DMEM_AW-1:0]  m_store_addr,
    input  logic [3:0]                  m_store_be,
    input  bk_pkg::word_t               m_store_word,
    output logic                        rf_we,
    output bk_pkg::reg_idx_t            rf_idx,
    output bk_pkg::word_t               rf_val,
    output logic                        store_commit,
    output logic [bk_pkg::DMEM_AW-1:0]  commit_addr,
    output logic [3:0]                  commit_be,
    output bk_pkg::word_t               commit_word,
    output logic                        fwd_valid,
    output bk_pkg::reg_idx_t            fwd_idx,
    output bk_pkg::word_t               fwd_val
);
    import bk_pkg::*;

    logic       ff_valid;
    logic       ff_rd_we;
    rd_src_e    ff_rd_src;
    mem_op_e    ff_mem_op;
    word_t      ff_alu_result;
    word_t      ff_load_val;
    word_t      ff_csr_val;
    word_t      rd_val;
    logic       live;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (!stall) begin
            ff_valid <= m_valid;
        end
    end

    // payload and store info, no reset
    always_ff @(posedge clk) begin
        if (!stall) begin
            rf_idx        <= m_rd_idx;
            ff_rd_we      <= m_rd_we;
            ff_rd_src     <= m_rd_src;
            ff_mem_op     <= m_mem_op;
            ff_alu_result <= m_alu_result;
            ff_load_val   <= m_load_val;
            ff_csr_val    <= m_csr_val;
            commit_addr   <= m_store_addr;
            commit_be     <= m_store_be;
            commit_word   <= m_store_word;
        end
    end

    // destination value
    always_comb begin
        case (ff_rd_src)
            RD_SRC_MEM: rd_val = ff_load_val;
            RD_SRC_CSR: rd_val = ff_csr_val;
            default:    rd_val = ff_alu_result;
        endcase
    end

    // flush kills only this slot, stall delays it
    assign live         = ff_valid && !flush && !stall;
    assign rf_we        = live && ff_rd_we;
    assign rf_val       = rd_val;
    assign store_commit = live && (ff_mem_op == MEM_OP_STORE);

    // forwarding mirrors the register write
    assign fwd_valid = rf_we;
    assign fwd_idx   = rf_idx;
    assign fwd_val   = rd_val;

    // a store carries no destination register
    a_write_xor_commit: assert property (@(posedge clk) disable iff (!rst_n)
        !(rf_we && store_commit));

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
// integer register file, 32 x 32
// hardwired x0, one write port
// two read ports forwarded from writeback
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                we,
    input  bk_pkg::reg_idx_t    wr_idx,
    input  bk_pkg::word_t       wr_val,
    input  logic                fwd_valid,
    input  bk_pkg::reg_idx_t    fwd_idx,
    input  bk_pkg::word_t       fwd_val,
    input  bk_pkg::reg_idx_t    rs1_idx,
    input  bk_pkg::reg_idx_t    rs2_idx,
    output bk_pkg::word_t       rs1_val,
    output bk_pkg::word_t       rs2_val
);
    import bk_pkg::*;

    word_t regs [32];

    // x0 writes dropped, contents not reset
    always_ff @(posedge clk) begin
        if (we && wr_idx != 5'd0) begin
            regs[wr_idx] <= wr_val;
        end
    end

    // one read port
    // x0 reads zero, else in-flight write wins over storage
    function automatic word_t read_port(input reg_idx_t idx,
                                        input logic     f_valid,
                                        input reg_idx_t f_idx,
                                        input word_t    f_val,
                                        input word_t    stored);
        word_t res;
        if (idx == 5'd0) begin
            res = '0;
        end else if (f_valid && f_idx == idx) begin
            res = f_val;
        end else begin
            res = stored;
        end
        return res;
    endfunction

    assign rs1_val = read_port(rs1_idx, fwd_valid, fwd_idx, fwd_val, regs[rs1_idx]);
    assign rs2_val = read_port(rs2_idx, fwd_valid, fwd_idx, fwd_val, regs[rs2_idx]);

endmodule

`default_nettype wire

/* verilog/bk_top.sv */
// back end top level
// mem_stage, data_mem, writeback_stage and reg_file
`timescale 1ns/1ps
`default_nettype none

module bk_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                flush,
    input  logic                in_valid,
    input  bk_pkg::reg_idx_t    in_rd_idx,
    input  logic                in_rd_we,
    input  bk_pkg::rd_src_e     in_rd_src,
    input  bk_pkg::mem_op_e     in_mem_op,
    input  bk_pkg::mem_size_e   in_mem_size,
    input  logic                in_mem_unsigned,
    input  bk_pkg::word_t       in_alu_result,
    input  bk_pkg::word_t       in_store_data,
    input  bk_pkg::word_t       in_csr_val,
    input  bk_pkg::reg_idx_t    rs1_idx,
    input  bk_pkg::reg_idx_t    rs2_idx,
    output logic                rf_we,
    output bk_pkg::reg_idx_t    rf_idx,
    output bk_pkg::word_t       rf_val,
    output logic                store_commit,
    output bk_pkg::word_t       rs1_val,
    output bk_pkg::word_t       rs2_val
);
    import bk_pkg::*;

    // data memory read side
    logic [DMEM_AW-1:0] dmem_addr;
    word_t              dmem_word;

    // mem_stage to writeback_stage
    logic               m_valid;
    reg_idx_t           m_rd_idx;
    logic               m_rd_we;
    rd_src_e            m_rd_src;
    mem_op_e            m_mem_op;
    word_t              m_alu_result;
    word_t              m_load_val;
    word_t              m_csr_val;
    logic [DMEM_AW-1:0] m_store_addr;
    logic [3:0]         m_store_be;
    word_t              m_store_word;

    // commit port and forwarding
    logic [DMEM_AW-1:0] commit_addr;
    logic [3:0]         commit_be;
    word_t              commit_word;
    logic               fwd_valid;
    reg_idx_t           fwd_idx;
    word_t              fwd_val;

    mem_stage i_mem_stage (
        .clk, .rst_n, .stall,
        .in_valid, .in_rd_idx, .in_rd_we, .in_rd_src, .in_mem_op, .in_mem_size,
        .in_mem_unsigned, .in_alu_result, .in_store_data, .in_csr_val,
        .dmem_addr, .dmem_word,
        .m_valid, .m_rd_idx, .m_rd_we, .m_rd_src, .m_mem_op, .m_alu_result,
        .m_load_val, .m_csr_val, .m_store_addr, .m_store_be, .m_store_word
    );

    data_mem i_data_mem (
        .clk, .rd_addr(dmem_addr), .rd_word(dmem_word),
        .commit(store_commit), .commit_addr, .commit_be, .commit_word
    );

    writeback_stage i_writeback_stage (
        .clk, .rst_n, .stall, .flush,
        .m_valid, .m_rd_idx, .m_rd_we, .m_rd_src, .m_mem_op, .m_alu_result,
        .m_load_val, .m_csr_val, .m_store_addr, .m_store_be, .m_store_word,
        .rf_we, .rf_idx, .rf_val, .store_commit, .commit_addr, .commit_be, .commit_word,
        .fwd_valid, .fwd_idx, .fwd_val
    );

    // register write port doubles as the observable write
    reg_file i_reg_file (
        .clk, .we(rf_we), .wr_idx(rf_idx), .wr_val(rf_val),
        .fwd_valid, .fwd_idx, .fwd_val,
        .rs1_idx, .rs2_idx, .rs1_val, .rs2_val
    );

endmodule

`default_nettype wire

/* sim/bk_checker.sv */
// reference model and output checks for the back end
// two-slot model pipeline, 64-word memory, 32 registers
// per-test report lines and error counts
`timescale 1ns/1ps
`default_nettype none

module bk_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                flush,
    input  logic                in_valid,
    input  bk_pkg::reg_idx_t    in_rd_idx,
    input  logic                in_rd_we,
    input  bk_pkg::rd_src_e     in_rd_src,
    input  bk_pkg::mem_op_e     in_mem_op,
    input  bk_pkg::mem_size_e   in_mem_size,
    input  logic                in_mem_unsigned,
    input  bk_pkg::word_t       in_alu_result,
    input  bk_pkg::word_t       in_store_data,
    input  bk_pkg::word_t       in_csr_val,
    input  bk_pkg::reg_idx_t    rs1_idx,
    input  bk_pkg::reg_idx_t    rs2_idx,
    input  logic                rf_we,
    input  bk_pkg::reg_idx_t    rf_idx,
    input  bk_pkg::word_t       rf_val,
    input  logic                store_commit,
    input  bk_pkg::word_t       rs1_val,
    input  bk_pkg::word_t       rs2_val,
    input  int                  test_id,
    input  logic                test_end,
    output int                  err_count,
    output int                  check_count
);
    import bk_pkg::*;

    // memory slot of the model
    logic        m_valid = 1'b0;
    reg_idx_t    m_rd_idx;
    logic        m_rd_we;
    rd_src_e     m_rd_src;
    mem_op_e     m_mem_op;
    mem_size_e   m_size;
    logic        m_uns;
    word_t       m_alu;
    word_t       m_sdata;
    word_t       m_csr;
    // writeback slot, value already resolved
    logic        w_valid = 1'b0;
    reg_idx_t    w_rd_idx;
    logic        w_rd_we;
    mem_op_e     w_mem_op;
    mem_size_e   w_size;
    word_t       w_addr;
    word_t       w_sdata;
    word_t       w_val;
    // architectural state
    word_t       mem_model [DMEM_WORDS];
    word_t       regs [32];
    logic [31:0] reg_known = '0;
    // this cycle's expectations
    logic        exp_we;
    logic        exp_commit;
    word_t       ld_val;
    int          cycle = 0;
    int          errs = 0;
    int          checks = 0;
    int          test_errs = 0;
    int          test_checks = 0;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic string test_name(input int id);
        case (id)
            1: return "alu_csr";
            2: return "x0_and_forwarding";
            3: return "load_store";
            4: return "stall";
            5: return "flush";
            default: return "unnamed";
        endcase
    endfunction

    // addressed bytes, sign or zero extended
    function automatic word_t load_value(input word_t w, input logic [1:0] off,
                                         input mem_size_e size, input logic uns);
        word_t sh;
        word_t res;
        sh = w >> (8 * off);
        case (size)
            MEM_SIZE_BYTE: res = uns ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            MEM_SIZE_HALF: res = uns ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default:       res = w;
        endcase
        return res;
    endfunction

    task automatic compare_value(input string name, input word_t exp, input word_t act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            errs++;
            test_errs++;
            $display("CHECK FAILED %s: expected 0x%08h, got 0x%08h at cycle %0d",
                     name, exp, act, cycle);
        end
    endtask

    // x0 first, then the write in flight, then a known register
    task automatic expect_read(input string name, input reg_idx_t idx, input word_t act);
        logic fwd;
        fwd = exp_we && (w_rd_idx == idx);
        if (idx == 5'd0) begin
            compare_value(name, 32'h0, act);
        end else if (fwd && !$isunknown(w_val)) begin
            compare_value(name, w_val, act);
        end else if (!fwd && reg_known[idx]) begin
            compare_value(name, regs[idx], act);
        end
    endtask

    // only the lanes of the access change
    task automatic commit_store();
        logic [DMEM_AW-1:0] wa;
        int                 base;
        wa   = w_addr[DMEM_AW+1:2];
        base = 8 * w_addr[1:0];
        case (w_size)
            MEM_SIZE_BYTE: mem_model[wa][base +: 8]  = w_sdata[7:0];
            MEM_SIZE_HALF: mem_model[wa][base +: 16] = w_sdata[15:0];
            default:       mem_model[wa]             = w_sdata;
        endcase
    endtask

    // inputs here are the ones the next rising edge samples
    always @(negedge clk) begin
        cycle++;
        exp_we     = 1'b0;
        exp_commit = 1'b0;
        if (rst_n) begin
            exp_we     = w_valid && w_rd_we && !flush && !stall;
            exp_commit = w_valid && (w_mem_op == MEM_OP_STORE) && !flush && !stall;
            compare_value("rf_we", 32'(exp_we), 32'(rf_we));
            compare_value("store_commit", 32'(exp_commit), 32'(store_commit));
            if (exp_we) begin
                compare_value("rf_idx", 32'(w_rd_idx), 32'(rf_idx));
                if (!$isunknown(w_val)) begin
                    compare_value("rf_val", w_val, rf_val);
                end
            end
            expect_read("rs1_val", rs1_idx, rs1_val);
            expect_read("rs2_val", rs2_idx, rs2_val);
        end
        // advance the model as the coming edge will
        if (!rst_n) begin
            m_valid = 1'b0;
            w_valid = 1'b0;
        end else if (!stall) begin
            if (exp_we && w_rd_idx != 5'd0) begin
                regs[w_rd_idx]      = w_val;
                reg_known[w_rd_idx] = !$isunknown(w_val);
            end
            // commit lands before the next load reads
            if (exp_commit) begin
                commit_store();
            end
            ld_val = load_value(mem_model[m_alu[DMEM_AW+1:2]], m_alu[1:0], m_size, m_uns);
            case (m_rd_src)
                RD_SRC_MEM: w_val = ld_val;
                RD_SRC_CSR: w_val = m_csr;
                default:    w_val = m_alu;
            endcase
            w_valid  = m_valid;
            w_rd_idx = m_rd_idx;
            w_rd_we  = m_rd_we;
            w_mem_op = m_mem_op;
            w_size   = m_size;
            w_addr   = m_alu;
            w_sdata  = m_sdata;
            m_valid  = in_valid;
            m_rd_idx = in_rd_idx;
            m_rd_we  = in_rd_we;
            m_rd_src = in_rd_src;
            m_mem_op = in_mem_op;
            m_size   = in_mem_size;
            m_uns    = in_mem_unsigned;
            m_alu    = in_alu_result;
            m_sdata  = in_store_data;
            m_csr    = in_csr_val;
        end
        if (test_end) begin
            $display("test %0d %s done: %0d checks, %0d errors",
                     test_id, test_name(test_id), test_checks, test_errs);
            test_checks = 0;
            test_errs   = 0;
        end
    end

endmodule

`default_nettype wire

/* sim/bk_tb.sv */
// testbench top for the pipeline back end
// clock, reset, LFSR stimulus per test phase
// cycle-count timeout, DUT and checker instances
`timescale 1ns/1ps
`default_nettype none

module bk_tb;
    import bk_pkg::*;

    localparam int          CLK_HALF  = 50;
    localparam int          DRIVE_DLY = 2;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int          N_TESTS   = 5;
    localparam int          LEN_ALU   = 200;
    localparam int          LEN_X0    = 120;
    localparam int          LEN_MEM   = 400;
    localparam int          LEN_STALL = 300;
    localparam int          LEN_FLUSH = 300;
    localparam int          DRAIN     = 4;
    // reset, all phases, drain plus end pulse per test, and some slack
    localparam int CYCLE_LIMIT = 2 + LEN_ALU + LEN_X0 + LEN_MEM + LEN_STALL + LEN_FLUSH
                                 + N_TESTS * (DRAIN + 1) + 50;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        in_valid;
    reg_idx_t    in_rd_idx;
    logic        in_rd_we;
    rd_src_e     in_rd_src;
    mem_op_e     in_mem_op;
    mem_size_e   in_mem_size;
    logic        in_mem_unsigned;
    word_t       in_alu_result;
    word_t       in_store_data;
    word_t       in_csr_val;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    logic        rf_we;
    reg_idx_t    rf_idx;
    word_t       rf_val;
    logic        store_commit;
    word_t       rs1_val;
    word_t       rs2_val;
    int          test_id;
    logic        test_end;
    int          err_count;
    int          check_count;
    logic [31:0] lfsr = 32'h995f;
    reg_idx_t    idx_hist [2];
    logic [5:0]  last_wa;
    int          cycles;

    bk_top i_dut (.*);

    bk_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // galois LFSR, one step per bit taken, msb first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic set_idle();
        in_valid        = 1'b0;
        in_rd_idx       = '0;
        in_rd_we        = 1'b0;
        in_rd_src       = RD_SRC_ALU;
        in_mem_op       = MEM_OP_NONE;
        in_mem_size     = MEM_SIZE_WORD;
        in_mem_unsigned = 1'b0;
        in_alu_result   = '0;
        in_store_data   = '0;
        in_csr_val      = '0;
        stall           = 1'b0;
        flush           = 1'b0;
    endtask

    // alu or csr result, sometimes a bubble or no write
    task automatic alu_csr_op();
        in_valid      = take_bits(2) != 0;
        in_rd_idx     = 5'(take_bits(5));
        in_rd_we      = take_bits(3) != 0;
        in_rd_src     = take_bits(1) != 0 ? RD_SRC_CSR : RD_SRC_ALU;
        in_alu_result = take_bits(32);
        in_csr_val    = take_bits(32);
    endtask

    // x0 often, reads aimed at the slot in writeback
    task automatic x0_op();
        in_valid      = 1'b1;
        in_rd_we      = 1'b1;
        in_rd_idx     = take_bits(1) != 0 ? 5'd0 : 5'(take_bits(5));
        in_alu_result = take_bits(32);
        rs1_idx       = idx_hist[1];
        rs2_idx       = take_bits(1) != 0 ? 5'd0 : idx_hist[1];
    endtask

    // word store so the whole memory holds known data
    task automatic fill_word(input int wa);
        in_valid      = 1'b1;
        in_mem_op     = MEM_OP_STORE;
        in_mem_size   = MEM_SIZE_WORD;
        in_alu_result = {24'(take_bits(24)), 6'(wa), 2'b00};
        in_store_data = take_bits(32);
    endtask

    // aligned load or store, half the time to the previous word
    task automatic load_store_op(input logic wide);
        logic [5:0] wa;
        logic [1:0] off;
        wa = wide ? 6'(take_bits(6)) : {3'b000, 3'(take_bits(3))};
        if (take_bits(1) != 0) begin
            wa = last_wa;
        end
        case (2'(take_bits(2)))
            2'd0: in_mem_size = MEM_SIZE_BYTE;
            2'd1: in_mem_size = MEM_SIZE_HALF;
            default: in_mem_size = MEM_SIZE_WORD;
        endcase
        case (in_mem_size)
            MEM_SIZE_BYTE: off = 2'(take_bits(2));
            MEM_SIZE_HALF: off = {1'(take_bits(1)), 1'b0};
            default: off = 2'b00;
        endcase
        in_valid        = 1'b1;
        in_alu_result   = {24'(take_bits(24)), wa, off};
        in_mem_unsigned = 1'(take_bits(1));
        if (take_bits(1) != 0) begin
            // stores carry no destination
            in_mem_op     = MEM_OP_STORE;
            in_store_data = take_bits(32);
        end else begin
            in_mem_op = MEM_OP_LOAD;
            in_rd_we  = 1'b1;
            in_rd_src = RD_SRC_MEM;
            in_rd_idx = 5'(take_bits(5));
        end
        last_wa = wa;
    endtask

    task automatic mixed_op();
        if (take_bits(1) != 0) begin
            alu_csr_op();
        end else begin
            load_store_op(1'b0);
        end
    endtask

    // one test: len driven cycles, drain, then end pulse
    task automatic run_phase(input int id, input int len);
        test_id = id;
        for (int c = 0; c < len; c++) begin
            @(posedge clk);
            #DRIVE_DLY;
            set_idle();
            rs1_idx = 5'(take_bits(5));
            rs2_idx = 5'(take_bits(5));
            case (id)
                1: alu_csr_op();
                2: x0_op();
                3: begin
                    if (c < DMEM_WORDS) begin
                        fill_word(c);
                    end else begin
                        load_store_op(1'b1);
                    end
                end
                4: begin
                    stall = take_bits(2) == 0;
                    mixed_op();
                end
                default: begin
                    flush = take_bits(2) == 0;
                    mixed_op();
                end
            endcase
            idx_hist[1] = idx_hist[0];
            idx_hist[0] = in_rd_idx;
        end
        // let the pipeline empty before the test is closed
        repeat (DRAIN) begin
            @(posedge clk);
            #DRIVE_DLY;
            set_idle();
        end
        test_end = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        test_end = 1'b0;
    endtask

    initial begin
        set_idle();
        rst_n       = 1'b0;
        rs1_idx     = '0;
        rs2_idx     = '0;
        test_id     = 0;
        test_end    = 1'b0;
        idx_hist[0] = '0;
        idx_hist[1] = '0;
        last_wa     = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        run_phase(1, LEN_ALU);
        run_phase(2, LEN_X0);
        run_phase(3, LEN_MEM);
        run_phase(4, LEN_STALL);
        run_phase(5, LEN_FLUSH);
        @(posedge clk);
        $display("summary: %0d tests, %0d checks, %0d errors", N_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/bk_pkg.sv
verilog/data_mem.sv
verilog/mem_stage.sv
verilog/writeback_stage.sv
verilog/reg_file.sv
verilog/bk_top.sv
sim/bk_checker.sv
sim/bk_tb.sv

/* run.sh */
#!/bin/sh
# build and run the back end testbench with Verilator
# exit status is nonzero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv --top-module bk_tb \
    -Mdir "$BUILD_DIR" -o bk_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/bk_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
exit 0
